// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = axis_mm_tb
FILELIST = axis_mm_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: axis_mm_top.f
+incdir+include
hdl/axis_mm_pkg.sv
hdl/axis_fifo.sv
hdl/block_mac.sv
hdl/mm_core.sv
hdl/axis_mm_ctrl.sv
hdl/axis_mm_top.sv
verif/axis_mm_assertions.sv
verif/axis_mm_tb.sv

// File: hdl/axis_fifo.sv
// Synchronous first-word-fall-through FIFO with AXI-Stream ports and occupancy count
`timescale 1ns/100ps
`default_nettype none

`include "axis_mm_cfg.svh"

module axis_fifo
    import axis_mm_pkg::*;
#(
    parameter int DEPTH = `MM_FIFO_DEPTH
)
(
    input  wire             aclk,
    input  wire             aresetn,
    input  wire blk_word_t  s_tdata,
    input  wire             s_tvalid,
    input  wire             s_tlast,
    output logic            s_tready,
    output blk_word_t       m_tdata,
    output logic            m_tvalid,
    output logic            m_tlast,
    input  wire             m_tready,
    output fifo_cnt_t       count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    blk_word_t          data_mem [DEPTH];
    logic               last_mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic               push;
    logic               pop;

    assign s_tready = (count != fifo_cnt_t'(DEPTH)); // Not full
    assign m_tvalid = (count != '0);
    assign m_tdata  = data_mem[rd_ptr];              // Head word falls through
    assign m_tlast  = last_mem[rd_ptr];

    assign push = s_tvalid && s_tready;
    assign pop  = m_tvalid && m_tready;

    // Storage, written only on accepted words
    always_ff @(posedge aclk)
    begin
        if (push)
        begin
            data_mem[wr_ptr] <= s_tdata;
            last_mem[wr_ptr] <= s_tlast;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // Idle or simultaneous push and pop
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/axis_mm_ctrl.sv
// Job controller that loads the core from the input FIFOs, starts it and drains C
`timescale 1ns/100ps
`default_nettype none

`include "axis_mm_cfg.svh"

module axis_mm_ctrl
    import axis_mm_pkg::*;
(
    input  wire             aclk,
    input  wire             aresetn,
    input  wire fifo_cnt_t  a_count,
    input  wire fifo_cnt_t  b_count,
    output logic            a_pop,
    output logic            b_pop,
    output logic            load_en,
    output blk_addr_t       load_addr,
    output logic            core_start,
    input  wire             core_done,
    output blk_addr_t       rd_addr,
    output logic            out_valid,
    output logic            out_last,
    input  wire             out_ready
);

    localparam fifo_cnt_t FULL_JOB = fifo_cnt_t'(`MM_NUM_BLOCKS);
    localparam blk_addr_t LAST_BLK = blk_addr_t'(`MM_NUM_BLOCKS-1);

    ctrl_state_t    state_reg;
    ctrl_state_t    state_next;
    blk_addr_t      cnt_reg;    // Load address, later read address
    blk_addr_t      cnt_next;
    logic           start_reg;
    logic           start_next;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state_reg <= IDLE;
            cnt_reg   <= '0;
            start_reg <= 1'b0;
        end
        else
        begin
            state_reg <= state_next;
            cnt_reg   <= cnt_next;
            start_reg <= start_next;
        end
    end

    always_comb
    begin
        state_next = state_reg;
        cnt_next   = cnt_reg;
        start_next = 1'b0;
        case (state_reg)
            IDLE:
            begin
                // Both matrices fully buffered
                if ((a_count >= FULL_JOB) && (b_count >= FULL_JOB))
                begin
                    state_next = LOAD;
                    cnt_next   = '0;
                end
            end
            LOAD:
            begin
                cnt_next = cnt_reg + 1'b1;   // One word per cycle, never stalls
                if (cnt_reg == LAST_BLK)
                begin
                    state_next = RUN;
                    start_next = 1'b1;       // Start pulse in the first RUN cycle
                end
            end
            RUN:
            begin
                if (core_done)
                begin
                    state_next = DRAIN;
                    cnt_next   = '0;
                end
            end
            DRAIN:
            begin
                if (out_ready)
                begin
                    cnt_next = cnt_reg + 1'b1;
                    if (cnt_reg == LAST_BLK)
                        state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    assign a_pop      = (state_reg == LOAD);
    assign b_pop      = (state_reg == LOAD);
    assign load_en    = (state_reg == LOAD);
    assign load_addr  = cnt_reg;
    assign core_start = start_reg;

    // Push side of the output FIFO, data comes from the core directly
    assign rd_addr    = cnt_reg;
    assign out_valid  = (state_reg == DRAIN);
    assign out_last   = out_valid && (cnt_reg == LAST_BLK);

endmodule

`default_nettype wire

// File: hdl/axis_mm_pkg.sv
// Shared types of the AXI-Stream block matrix multiplier
`default_nettype none

`include "axis_mm_cfg.svh"

package axis_mm_pkg;

    // Signed Q8.8 matrix element
    typedef logic signed [15:0] elem_t;

    // Sum of four full 32-bit products, no overflow possible
    typedef logic signed [35:0] acc_t;

    // One 2x2 block, element (r,c) at position 2*r+c, position 0 in the low bits
    typedef logic [63:0] blk_word_t;

    // Block address inside A, B or C
    typedef logic [$clog2(`MM_NUM_BLOCKS)-1:0] blk_addr_t;

    // FIFO occupancy, 0 up to full depth
    typedef logic [$clog2(`MM_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

    // Controller FSM
    typedef enum logic [1:0]
    {
        IDLE,
        LOAD,
        RUN,
        DRAIN
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/axis_mm_top.sv
// AXI-Stream block matrix multiplier top, A and B in, C = A*B out
`timescale 1ns/100ps
`default_nettype none

module axis_mm_top
    import axis_mm_pkg::*;
(
    input  wire             aclk,
    input  wire             aresetn,
    input  wire blk_word_t  s_axis_a_tdata,
    input  wire             s_axis_a_tvalid,
    output wire             s_axis_a_tready,
    input  wire blk_word_t  s_axis_b_tdata,
    input  wire             s_axis_b_tvalid,
    output wire             s_axis_b_tready,
    output wire blk_word_t  m_axis_c_tdata,
    output wire             m_axis_c_tvalid,
    input  wire             m_axis_c_tready,
    output wire             m_axis_c_tlast
);

    blk_word_t  a_data;
    blk_word_t  b_data;
    blk_word_t  c_data;
    fifo_cnt_t  a_count;
    fifo_cnt_t  b_count;
    logic       a_pop;
    logic       b_pop;
    logic       load_en;
    blk_addr_t  load_addr;
    logic       core_start;
    logic       core_done;
    blk_addr_t  rd_addr;
    logic       out_valid;
    logic       out_last;
    logic       out_ready;

    // Matrix A input buffer
    axis_fifo a_fifo
    (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .s_tdata  (s_axis_a_tdata),
        .s_tvalid (s_axis_a_tvalid),
        .s_tlast  (1'b0),
        .s_tready (s_axis_a_tready),
        .m_tdata  (a_data),
        .m_tvalid (),
        .m_tlast  (),
        .m_tready (a_pop),
        .count    (a_count)
    );

    // Matrix B input buffer
    axis_fifo b_fifo
    (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .s_tdata  (s_axis_b_tdata),
        .s_tvalid (s_axis_b_tvalid),
        .s_tlast  (1'b0),
        .s_tready (s_axis_b_tready),
        .m_tdata  (b_data),
        .m_tvalid (),
        .m_tlast  (),
        .m_tready (b_pop),
        .count    (b_count)
    );

    axis_mm_ctrl ctrl0
    (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .a_count    (a_count),
        .b_count    (b_count),
        .a_pop      (a_pop),
        .b_pop      (b_pop),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .core_start (core_start),
        .core_done  (core_done),
        .rd_addr    (rd_addr),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .out_ready  (out_ready)
    );

    mm_core core0
    (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .load_en   (load_en),
        .load_addr (load_addr),
        .a_din     (a_data),
        .b_din     (b_data),
        .start     (core_start),
        .done      (core_done),
        .rd_addr   (rd_addr),
        .rd_data   (c_data)
    );

    // Result buffer towards the C master port
    axis_fifo c_fifo
    (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .s_tdata  (c_data),
        .s_tvalid (out_valid),
        .s_tlast  (out_last),
        .s_tready (out_ready),
        .m_tdata  (m_axis_c_tdata),
        .m_tvalid (m_axis_c_tvalid),
        .m_tlast  (m_axis_c_tlast),
        .m_tready (m_axis_c_tready),
        .count    ()
    );

endmodule

`default_nettype wire

// File: hdl/block_mac.sv
// 2x2 block multiply-accumulate with Q8.8 rescale and saturation
`timescale 1ns/100ps
`default_nettype none

`include "axis_mm_cfg.svh"

module block_mac
    import axis_mm_pkg::*;
(
    input  wire             aclk,
    input  wire             aresetn,
    input  wire             clear,
    input  wire             enable,
    input  wire blk_word_t  a_blk,
    input  wire blk_word_t  b_blk,
    output wire blk_word_t  c_blk
);

    localparam int   EW       = $bits(elem_t);
    localparam acc_t ELEM_MAX = 36'sd32767;
    localparam acc_t ELEM_MIN = -36'sd32768;

    // Drop the fraction of the product sum, clamp to the element range
    function automatic elem_t sat_elem(input acc_t v);
        acc_t shifted;
        shifted = v >>> `MM_FRAC_WIDTH;
        if (shifted > ELEM_MAX)
            return 16'sh7fff;
        else if (shifted < ELEM_MIN)
            return 16'sh8000;
        else
            return elem_t'(shifted[EW-1:0]);
    endfunction

    for (genvar r = 0; r < `MM_GRID; r++)
    begin : g_row
        for (genvar c = 0; c < `MM_GRID; c++)
        begin : g_col
            localparam int P = r * `MM_GRID + c; // Position of (r,c) in the block word

            acc_t dot;
            acc_t acc_reg;

            // Row r of A times column c of B
            always_comb
            begin
                elem_t                  a_e;
                elem_t                  b_e;
                logic signed [2*EW-1:0] prod;
                dot = '0;
                for (int k = 0; k < `MM_GRID; k++)
                begin
                    a_e  = elem_t'(a_blk[EW*(r*`MM_GRID+k) +: EW]);
                    b_e  = elem_t'(b_blk[EW*(k*`MM_GRID+c) +: EW]);
                    prod = a_e * b_e;
                    dot  = dot + acc_t'(prod);
                end
            end

            always_ff @(posedge aclk)
            begin
                if (!aresetn)
                    acc_reg <= '0;
                else if (enable)
                    acc_reg <= clear ? dot : acc_reg + dot; // Clear opens a new C block
            end

            assign c_blk[EW*P +: EW] = sat_elem(acc_reg);
        end
    end

endmodule

`default_nettype wire

// File: hdl/mm_core.sv
// Block matrix multiply core with A/B block buffers, k-step sequencer and result buffer
`timescale 1ns/100ps
`default_nettype none

`include "axis_mm_cfg.svh"

module mm_core
    import axis_mm_pkg::*;
(
    input  wire             aclk,
    input  wire             aresetn,
    input  wire             load_en,
    input  wire blk_addr_t  load_addr,
    input  wire blk_word_t  a_din,
    input  wire blk_word_t  b_din,
    input  wire             start,
    output logic            done,
    input  wire blk_addr_t  rd_addr,
    output blk_word_t       rd_data
);

    // Two k-steps per output block
    localparam int STEPS  = `MM_NUM_BLOCKS * `MM_GRID;
    localparam int STEP_W = $clog2(STEPS);

    blk_word_t          a_mem [`MM_NUM_BLOCKS];
    blk_word_t          b_mem [`MM_NUM_BLOCKS];
    blk_word_t          c_mem [`MM_NUM_BLOCKS];

    logic               busy;
    logic [STEP_W-1:0]  step;
    logic               k_idx;
    blk_addr_t          out_idx;
    blk_addr_t          a_sel;
    blk_addr_t          b_sel;
    logic               wb_en;
    blk_addr_t          wb_addr;
    blk_word_t          mac_out;

    // Step splits into output block (i,j) and inner index k
    assign k_idx   = step[0];
    assign out_idx = step[STEP_W-1:1];
    assign a_sel   = {out_idx[1], k_idx}; // A block (i,k)
    assign b_sel   = {k_idx, out_idx[0]}; // B block (k,j)

    // Input block buffers
    always_ff @(posedge aclk)
    begin
        if (load_en)
        begin
            a_mem[load_addr] <= a_din;
            b_mem[load_addr] <= b_din;
        end
    end

    // Sequencer, eight MAC cycles then one write-back cycle
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            busy  <= 1'b0;
            step  <= '0;
            wb_en <= 1'b0;
            done  <= 1'b0;
        end
        else
        begin
            wb_en <= busy && k_idx;                              // Block complete after k=1
            done  <= busy && (step == STEP_W'(STEPS-1));         // Lines up with last write
            if (busy)
            begin
                step <= step + 1'b1;
                if (step == STEP_W'(STEPS-1))
                    busy <= 1'b0;
            end
            else if (start)
            begin
                busy <= 1'b1;
                step <= '0;
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        wb_addr <= out_idx;
    end

    block_mac mac0
    (
        .aclk    (aclk),
        .aresetn (aresetn),
        .clear   (!k_idx),
        .enable  (busy),
        .a_blk   (a_mem[a_sel]),
        .b_blk   (b_mem[b_sel]),
        .c_blk   (mac_out)
    );

    // Result buffer
    always_ff @(posedge aclk)
    begin
        if (wb_en)
            c_mem[wb_addr] <= mac_out;
    end

    assign rd_data = c_mem[rd_addr];

endmodule

`default_nettype wire

// File: include/axis_mm_cfg.svh
// Build-time configuration of the AXI-Stream block matrix multiplier

`ifndef AXIS_MM_CFG_SVH
`define AXIS_MM_CFG_SVH

// Q8.8 elements
`define MM_FRAC_WIDTH 8

// Blocks per matrix dimension (2x2 blocks of a 4x4 matrix)
`define MM_GRID 2

// Blocks per matrix, equals MM_GRID squared
`define MM_NUM_BLOCKS 4

// Default stream FIFO depth, room for two matrices
`define MM_FIFO_DEPTH 8

`endif

// File: verif/axis_mm_assertions.sv
// Concurrent protocol checks on the stream ports of the block matrix multiplier
`timescale 1ns/100ps
`default_nettype none

`include "axis_mm_cfg.svh"

module axis_mm_assertions
    import axis_mm_pkg::*;
(
    input wire              aclk,
    input wire              aresetn,
    input wire              m_axis_c_tvalid,
    input wire              m_axis_c_tready,
    input wire blk_word_t   m_axis_c_tdata,
    input wire              m_axis_c_tlast,
    input wire              s_axis_a_tvalid,
    input wire              s_axis_a_tready,
    input wire              s_axis_b_tvalid,
    input wire              s_axis_b_tready,
    input wire              a_pop,
    input wire              b_pop
);

    localparam fifo_cnt_t FULL = fifo_cnt_t'(`MM_FIFO_DEPTH);

    fifo_cnt_t  a_fill;     // Words in the A FIFO, counted from its handshakes
    fifo_cnt_t  b_fill;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            a_fill <= '0;
            b_fill <= '0;
        end
        else
        begin
            a_fill <= a_fill + fifo_cnt_t'(s_axis_a_tvalid && s_axis_a_tready)
                      - fifo_cnt_t'(a_pop);
            b_fill <= b_fill + fifo_cnt_t'(s_axis_b_tvalid && s_axis_b_tready)
                      - fifo_cnt_t'(b_pop);
        end
    end

    c_idle_in_reset: assert property (@(posedge aclk) !aresetn |=> !m_axis_c_tvalid)
        else $error("m_axis_c_tvalid is high while in reset");

    // Head word held under back-pressure
    c_hold_word: assert property (@(posedge aclk) disable iff (!aresetn)
        m_axis_c_tvalid && !m_axis_c_tready |=>
            m_axis_c_tvalid && $stable(m_axis_c_tdata) && $stable(m_axis_c_tlast))
        else $error("C word changed or was dropped before it was accepted");

    a_ready_with_room: assert property (@(posedge aclk) disable iff (!aresetn)
        (a_fill < FULL) |-> s_axis_a_tready)
        else $error("s_axis_a_tready is low while the A FIFO has room");

    b_ready_with_room: assert property (@(posedge aclk) disable iff (!aresetn)
        (b_fill < FULL) |-> s_axis_b_tready)
        else $error("s_axis_b_tready is low while the B FIFO has room");

endmodule

bind axis_mm_top axis_mm_assertions asrt0
(
    .aclk            (aclk),
    .aresetn         (aresetn),
    .m_axis_c_tvalid (m_axis_c_tvalid),
    .m_axis_c_tready (m_axis_c_tready),
    .m_axis_c_tdata  (m_axis_c_tdata),
    .m_axis_c_tlast  (m_axis_c_tlast),
    .s_axis_a_tvalid (s_axis_a_tvalid),
    .s_axis_a_tready (s_axis_a_tready),
    .s_axis_b_tvalid (s_axis_b_tvalid),
    .s_axis_b_tready (s_axis_b_tready),
    .a_pop           (a_pop),
    .b_pop           (b_pop)
);

`default_nettype wire

// File: verif/axis_mm_tb.sv
// Random-stimulus testbench for the AXI-Stream block matrix multiplier with a reference model
`timescale 1ns/100ps
`default_nettype none

`include "axis_mm_cfg.svh"

module axis_mm_tb
    import axis_mm_pkg::*;
();

    localparam int N       = `MM_GRID * 2;      // Matrix dimension
    localparam int EW      = $bits(elem_t);
    localparam int TIMEOUT = 400;               // Cycles allowed per wait

    logic       aclk            = 1'b0;
    logic       aresetn         = 1'b0;
    blk_word_t  s_axis_a_tdata  = '0;
    logic       s_axis_a_tvalid = 1'b0;
    wire        s_axis_a_tready;
    blk_word_t  s_axis_b_tdata  = '0;
    logic       s_axis_b_tvalid = 1'b0;
    wire        s_axis_b_tready;
    blk_word_t  m_axis_c_tdata;
    wire        m_axis_c_tvalid;
    logic       m_axis_c_tready = 1'b0;
    wire        m_axis_c_tlast;

    logic [15:0] lfsr = 16'd13;
    elem_t       a_m [N][N];
    elem_t       b_m [N][N];
    elem_t       c_m [N][N];
    blk_word_t   a_q [$];                       // Words still to send
    blk_word_t   b_q [$];
    blk_word_t   exp_q [$];                     // Expected C words in order
    logic        last_q [$];
    bit          a_go       = 1'b0;
    bit          b_go       = 1'b0;
    bit          valid_gaps = 1'b0;
    bit          ready_gaps = 1'b0;
    int          word_errs  = 0;
    int          flag_errs  = 0;
    int          timeouts   = 0;
    int          out_cnt    = 0;

    always #10 aclk = ~aclk;

    axis_mm_top dut0
    (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .s_axis_a_tdata  (s_axis_a_tdata),
        .s_axis_a_tvalid (s_axis_a_tvalid),
        .s_axis_a_tready (s_axis_a_tready),
        .s_axis_b_tdata  (s_axis_b_tdata),
        .s_axis_b_tvalid (s_axis_b_tvalid),
        .s_axis_b_tready (s_axis_b_tready),
        .m_axis_c_tdata  (m_axis_c_tdata),
        .m_axis_c_tvalid (m_axis_c_tvalid),
        .m_axis_c_tready (m_axis_c_tready),
        .m_axis_c_tlast  (m_axis_c_tlast)
    );

    // x^16 + x^15 + x^13 + x^4 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int b = 0; b < n; b++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    // Signed element of nbits random bits
    function automatic elem_t rand_elem(input int nbits);
        logic [15:0] v;
        elem_t       e;
        v = take_bits(nbits);
        e = elem_t'(v << (EW - nbits));
        return e >>> (EW - nbits);
    endfunction

    // Exact dot product, rescaled and clamped to Q8.8
    function automatic elem_t model_elem(input int i, input int j);
        longint sum;
        sum = 0;
        for (int k = 0; k < N; k++)
            sum += longint'(a_m[i][k]) * longint'(b_m[k][j]);
        sum = sum >>> `MM_FRAC_WIDTH;
        if (sum > 32767)
            return 16'sh7fff;
        if (sum < -32768)
            return 16'sh8000;
        return elem_t'(sum);
    endfunction

    // which selects A, B or C
    function automatic blk_word_t pack_blk(input int which, input int bi, input int bj);
        blk_word_t w;
        elem_t     e;
        w = '0;
        for (int r = 0; r < `MM_GRID; r++)
        begin
            for (int c = 0; c < `MM_GRID; c++)
            begin
                case (which)
                    0:       e = a_m[bi*`MM_GRID+r][bj*`MM_GRID+c];
                    1:       e = b_m[bi*`MM_GRID+r][bj*`MM_GRID+c];
                    default: e = c_m[bi*`MM_GRID+r][bj*`MM_GRID+c];
                endcase
                w[EW*(r*`MM_GRID+c) +: EW] = e;
            end
        end
        return w;
    endfunction

    task automatic check_word(input blk_word_t got, input blk_word_t exp, input string what);
        if (got !== exp)
        begin
            word_errs++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            flag_errs++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Kind 0 is random of nbits, kind 1 saturates in both directions
    task automatic build_job(input int kind, input int nbits);
        for (int i = 0; i < N; i++)
        begin
            for (int j = 0; j < N; j++)
            begin
                if (kind == 0)
                begin
                    a_m[i][j] = rand_elem(nbits);
                    b_m[i][j] = rand_elem(nbits);
                end
                else
                begin
                    a_m[i][j] = 16'sh7f00;                            // 127.0
                    b_m[i][j] = (j < N / 2) ? 16'sh7f00 : 16'sh8100;  // +-127.0
                end
            end
        end
        for (int i = 0; i < N; i++)
            for (int j = 0; j < N; j++)
                c_m[i][j] = model_elem(i, j);
        for (int addr = 0; addr < `MM_NUM_BLOCKS; addr++)
        begin
            a_q.push_back(pack_blk(0, addr / `MM_GRID, addr % `MM_GRID));
            b_q.push_back(pack_blk(1, addr / `MM_GRID, addr % `MM_GRID));
            exp_q.push_back(pack_blk(2, addr / `MM_GRID, addr % `MM_GRID));
            last_q.push_back(addr == `MM_NUM_BLOCKS - 1);
        end
    endtask

    // One clock of both sources and the C sink
    task automatic step_streams();
        logic [15:0] r;
        @(posedge aclk);
        if (s_axis_a_tvalid && s_axis_a_tready)
            void'(a_q.pop_front());
        if (!s_axis_a_tvalid || s_axis_a_tready)                  // Not holding a word
        begin
            r = valid_gaps ? take_bits(2) : 16'd1;
            s_axis_a_tvalid <= a_go && (a_q.size() > 0) && (r != 16'd0);
            if (a_q.size() > 0)
                s_axis_a_tdata <= a_q[0];
        end
        if (s_axis_b_tvalid && s_axis_b_tready)
            void'(b_q.pop_front());
        if (!s_axis_b_tvalid || s_axis_b_tready)
        begin
            r = valid_gaps ? take_bits(2) : 16'd1;
            s_axis_b_tvalid <= b_go && (b_q.size() > 0) && (r != 16'd0);
            if (b_q.size() > 0)
                s_axis_b_tdata <= b_q[0];
        end
        if (m_axis_c_tvalid && m_axis_c_tready)
        begin
            if (exp_q.size() == 0)
            begin
                word_errs++;
                $display("Output word %0d arrived although no job expected it", out_cnt);
            end
            else
            begin
                check_word(m_axis_c_tdata, exp_q.pop_front(), $sformatf("C word %0d", out_cnt));
                check_bit(m_axis_c_tlast, last_q.pop_front(), $sformatf("tlast %0d", out_cnt));
            end
            out_cnt++;
        end
        r = ready_gaps ? take_bits(1) : 16'd1;
        m_axis_c_tready <= r[0];
    endtask

    task automatic wait_b_sent();
        int n;
        n = 0;
        while ((b_q.size() > 0) && (n < TIMEOUT))
        begin
            step_streams();
            n++;
        end
        if (b_q.size() > 0)
        begin
            timeouts++;
            $display("Timeout while the B stream still had %0d words to send", b_q.size());
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((exp_q.size() > 0) && (n < TIMEOUT))
        begin
            step_streams();
            n++;
        end
        if (exp_q.size() > 0)
        begin
            timeouts++;
            $display("Timeout while %0d result words were still missing", exp_q.size());
        end
    endtask

    // Any word accepted in this window is one too many
    task automatic expect_silence(input int cycles);
        for (int n = 0; n < cycles; n++)
            step_streams();
    endtask

    initial
    begin
        repeat (5) @(posedge aclk);
        aresetn <= 1'b1;

        repeat (4)                              // Idle outputs after reset
        begin
            step_streams();
            check_bit(m_axis_c_tvalid, 1'b0, "m_axis_c_tvalid when idle");
            check_bit(s_axis_a_tready, 1'b1, "s_axis_a_tready when idle");
            check_bit(s_axis_b_tready, 1'b1, "s_axis_b_tready when idle");
        end

        a_go = 1'b1;
        b_go = 1'b1;
        build_job(0, 10);                       // Small values, no clamping
        wait_drained();
        build_job(1, 0);
        wait_drained();

        ready_gaps = 1'b1;
        build_job(0, 13);
        wait_drained();
        ready_gaps = 1'b0;

        valid_gaps = 1'b1;                      // B matrix first, A held back
        a_go       = 1'b0;
        build_job(0, 13);
        wait_b_sent();
        a_go = 1'b1;
        wait_drained();

        ready_gaps = 1'b1;                      // Two queued jobs
        build_job(0, 13);
        build_job(0, 13);
        wait_drained();
        ready_gaps = 1'b0;
        expect_silence(20);

        $display("Summary: %0d data errors, %0d flag errors, %0d timeouts, %0d words seen",
                 word_errs, flag_errs, timeouts, out_cnt);
        if ((word_errs + flag_errs + timeouts) == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
